/* cl_hello_pkg.sv */
/*
 * Hello-world peripheral shared types, register map and bus structs
 */

package cl_hello_pkg;

  // ------------------------------
  // Vector types
  // ------------------------------
  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;
  typedef logic [15:0] led_t;
  typedef logic [15:0] cnt_t;
  typedef logic [7:0]  tick_t;

  // AXI-Lite response codes
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // Controller FSM states
  typedef enum logic [2:0] {IDLE, WR_DATA, WR_RESP, RD_DECODE, RD_RESP} ocl_state_t;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam axil_addr_t HELLO_WORLD_ADDR = 32'h0000_0500;
  localparam axil_addr_t VLED_ADDR        = 32'h0000_0504;
  localparam axil_addr_t CNT_CTRL_ADDR    = 32'h0000_0510;
  localparam axil_addr_t CNT_TICK_ADDR    = 32'h0000_0514;
  localparam axil_addr_t CNT_LOAD_ADDR    = 32'h0000_0518;
  localparam axil_addr_t CNT_WMARK_ADDR   = 32'h0000_051C;
  localparam axil_addr_t CNT_STATUS_ADDR  = 32'h0000_0520;

  // CNT_CTRL fields, load and clear are write-only pulses
  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int CTRL_ONESHOT_BIT = 1;
  localparam int CTRL_LOAD_BIT    = 2;
  localparam int CTRL_CLEAR_BIT   = 3;

  // CNT_STATUS read layout
  localparam int STATUS_COUNT_LSB = 0;
  localparam int STATUS_TICK_LSB  = 16;
  localparam int STATUS_GE_BIT    = 24;

  // ------------------------------
  // Shared structs
  // ------------------------------
  // Single-cycle write enables plus the write data
  typedef struct packed {
    logic       hello_we;
    logic       cnt_ctrl_we;
    logic       cnt_tick_we;
    logic       cnt_load_we;
    logic       cnt_wmark_we;
    axil_data_t wdata;
  } reg_wr_t;

  // Counter readback bundle
  typedef struct packed {
    logic  enable;
    logic  oneshot;
    tick_t tick_value;
    cnt_t  load_value;
    cnt_t  watermark;
    tick_t tick_cnt;
    cnt_t  count;
    logic  ge_watermark;
  } cnt_rd_t;

endpackage

/* cl_hello_reg.sv */
/*
 * Hello-world register
 * Stores a full word and presents it byte-reversed for readback
 */
`timescale 1ns/10ps

module cl_hello_reg
  import cl_hello_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  reg_wr_t    reg_wr,
  output axil_data_t hello_q,
  output axil_data_t hello_swapped
);

  // ------------------------------
  // Storage
  // ------------------------------
  // New value visible on the strobe edge
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      hello_q <= '0;
    else if (reg_wr.hello_we)
      hello_q <= reg_wr.wdata;
  end

  // ------------------------------
  // Readback
  // ------------------------------
  // Byte 0 ends up in the top lane
  assign hello_swapped = {
    hello_q[7:0],
    hello_q[15:8],
    hello_q[23:16],
    hello_q[31:24]
  };

endmodule

/* cl_hello_world.sv */
/*
 * Hello-world custom logic top
 * AXI-Lite control plus hello register, virtual LED and tick counter
 */
`timescale 1ns/10ps

module cl_hello_world
  import cl_hello_pkg::*;
#(
  parameter int DIP_SYNC_STAGES = 2
)
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  // OCL AXI-Lite
  input  logic       awvalid,
  input  axil_addr_t awaddr,
  output logic       awready,
  input  logic       wvalid,
  input  axil_data_t wdata,
  // Full-word writes only, strobes are not decoded
  input  logic [3:0] wstrb,
  output logic       wready,
  output logic       bvalid,
  output axil_resp_t bresp,
  input  logic       bready,
  input  logic       arvalid,
  input  axil_addr_t araddr,
  output logic       arready,
  output logic       rvalid,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  input  logic       rready,
  // Virtual DIP and LED
  input  led_t       sh_cl_status_vdip,
  output led_t       cl_sh_status_vled
);

  reg_wr_t    reg_wr;
  axil_data_t hello_q;
  axil_data_t hello_swapped;
  led_t       vled_q;
  cnt_rd_t    cnt_rd;

  // ------------------------------
  // Control
  // ------------------------------
  cl_ocl_ctrl i_cl_ocl_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .hello_swapped   (hello_swapped),
    .vled_q          (vled_q),
    .cnt_rd          (cnt_rd),
    .reg_wr          (reg_wr)
  );

  // ------------------------------
  // Datapath
  // ------------------------------
  cl_hello_reg i_cl_hello_reg (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .hello_q         (hello_q),
    .hello_swapped   (hello_swapped)
  );

  // LEDs shadow the low hello half
  cl_vled #(
    .DIP_SYNC_STAGES (DIP_SYNC_STAGES)
  ) i_cl_vled (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_sync   (rst_main_n_sync),
    .hello_low         (hello_q[$bits(led_t)-1:0]),
    .sh_cl_status_vdip (sh_cl_status_vdip),
    .vled_q            (vled_q),
    .cl_sh_status_vled (cl_sh_status_vled)
  );

  cl_tick_counter i_cl_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .cnt_rd          (cnt_rd)
  );

endmodule

/* cl_ocl_ctrl.sv */
/*
 * OCL AXI-Lite slave, single beat only
 * Decodes writes into register strobes and muxes read data from the datapath
 */
`timescale 1ns/10ps

module cl_ocl_ctrl
  import cl_hello_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  // Write address and data
  input  logic       awvalid,
  input  axil_addr_t awaddr,
  output logic       awready,
  input  logic       wvalid,
  input  axil_data_t wdata,
  output logic       wready,
  // Write response
  output logic       bvalid,
  output axil_resp_t bresp,
  input  logic       bready,
  // Read address
  input  logic       arvalid,
  input  axil_addr_t araddr,
  output logic       arready,
  // Read response
  output logic       rvalid,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  input  logic       rready,
  // Datapath side
  input  axil_data_t hello_swapped,
  input  led_t       vled_q,
  input  cnt_rd_t    cnt_rd,
  output reg_wr_t    reg_wr
);

  ocl_state_t state_q;
  ocl_state_t state_d;
  axil_addr_t wr_addr_q;
  axil_addr_t rd_addr_q;
  axil_data_t rdata_q;
  axil_resp_t rresp_q;
  axil_data_t rd_word;
  axil_resp_t rd_resp;
  logic       aw_fire;
  logic       ar_fire;

  // ------------------------------
  // Handshake signals
  // ------------------------------
  // Write wins when both address channels arrive together
  assign awready = (state_q == IDLE);
  assign arready = (state_q == IDLE) && !awvalid;
  assign aw_fire = awvalid && awready;
  assign ar_fire = arvalid && arready;
  assign wready  = (state_q == WR_DATA) && wvalid;

  assign bvalid = (state_q == WR_RESP);
  // Unmapped writes are dropped but still answered OKAY
  assign bresp  = RESP_OKAY;
  assign rvalid = (state_q == RD_RESP);
  assign rdata  = rdata_q;
  assign rresp  = rresp_q;

  // ------------------------------
  // FSM
  // ------------------------------
  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      IDLE:
      begin
        if (aw_fire)
          state_d = WR_DATA;
        else if (ar_fire)
          state_d = RD_DECODE;
      end
      WR_DATA:   if (wvalid) state_d = WR_RESP;
      WR_RESP:   if (bready) state_d = IDLE;
      RD_DECODE: state_d = RD_RESP;
      RD_RESP:   if (rready) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // Address latches
  always_ff @(posedge clk_main_a0)
  begin
    if (aw_fire)
      wr_addr_q <= awaddr;
    if (ar_fire)
      rd_addr_q <= araddr;
  end

  // ------------------------------
  // Write decode
  // ------------------------------
  // One strobe per register, live only during the w handshake
  always_comb
  begin
    reg_wr.hello_we     = wready && (wr_addr_q == HELLO_WORLD_ADDR);
    reg_wr.cnt_ctrl_we  = wready && (wr_addr_q == CNT_CTRL_ADDR);
    reg_wr.cnt_tick_we  = wready && (wr_addr_q == CNT_TICK_ADDR);
    reg_wr.cnt_load_we  = wready && (wr_addr_q == CNT_LOAD_ADDR);
    reg_wr.cnt_wmark_we = wready && (wr_addr_q == CNT_WMARK_ADDR);
    reg_wr.wdata        = wdata;
  end

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb
  begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    unique case (rd_addr_q)
      HELLO_WORLD_ADDR: rd_word = hello_swapped;
      VLED_ADDR:        rd_word[$bits(led_t)-1:0] = vled_q;
      CNT_CTRL_ADDR:
      begin
        // Load and clear always read back as zero
        rd_word[CTRL_ENABLE_BIT]  = cnt_rd.enable;
        rd_word[CTRL_ONESHOT_BIT] = cnt_rd.oneshot;
      end
      CNT_TICK_ADDR:    rd_word[$bits(tick_t)-1:0] = cnt_rd.tick_value;
      CNT_LOAD_ADDR:    rd_word[$bits(cnt_t)-1:0]  = cnt_rd.load_value;
      CNT_WMARK_ADDR:   rd_word[$bits(cnt_t)-1:0]  = cnt_rd.watermark;
      CNT_STATUS_ADDR:
      begin
        rd_word[STATUS_COUNT_LSB +: $bits(cnt_t)] = cnt_rd.count;
        rd_word[STATUS_TICK_LSB +: $bits(tick_t)] = cnt_rd.tick_cnt;
        rd_word[STATUS_GE_BIT]                    = cnt_rd.ge_watermark;
      end
      default:          rd_resp = RESP_SLVERR;
    endcase
  end

  // Captured once in RD_DECODE, then held through back-pressure
  always_ff @(posedge clk_main_a0)
  begin
    if (state_q == RD_DECODE)
    begin
      rdata_q <= rd_word;
      rresp_q <= rd_resp;
    end
  end

  // ------------------------------
  // Assertions
  // ------------------------------
  // Only one transaction in flight
  a_one_resp: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(bvalid && rvalid));

  // Read response held under back-pressure
  a_rdata_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)));

endmodule

/* cl_tick_counter.sv */
/*
 * Tick and event counter with register control
 * Enable, one-shot saturation, load, clear and watermark flag
 */
`timescale 1ns/10ps

module cl_tick_counter
  import cl_hello_pkg::*;
(
  input  logic    clk_main_a0,
  input  logic    rst_main_n_sync,
  input  reg_wr_t reg_wr,
  output cnt_rd_t cnt_rd
);

  logic  enable_q;
  logic  oneshot_q;
  tick_t tick_value_q;
  cnt_t  load_value_q;
  cnt_t  watermark_q;
  tick_t tick_cnt_q;
  cnt_t  count_q;
  logic  load_pulse;
  logic  clear_pulse;
  logic  tick_hit;
  logic  count_sat;

  // Self-clearing command bits, only live on the CNT_CTRL write
  assign load_pulse  = reg_wr.cnt_ctrl_we && reg_wr.wdata[CTRL_LOAD_BIT];
  assign clear_pulse = reg_wr.cnt_ctrl_we && reg_wr.wdata[CTRL_CLEAR_BIT];

  // ------------------------------
  // Configuration registers
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      enable_q     <= 1'b0;
      oneshot_q    <= 1'b0;
      tick_value_q <= '0;
      load_value_q <= '0;
      watermark_q  <= '0;
    end
    else
    begin
      if (reg_wr.cnt_ctrl_we)
      begin
        enable_q  <= reg_wr.wdata[CTRL_ENABLE_BIT];
        oneshot_q <= reg_wr.wdata[CTRL_ONESHOT_BIT];
      end
      if (reg_wr.cnt_tick_we)
        tick_value_q <= reg_wr.wdata[$bits(tick_t)-1:0];
      if (reg_wr.cnt_load_we)
        load_value_q <= reg_wr.wdata[$bits(cnt_t)-1:0];
      if (reg_wr.cnt_wmark_we)
        watermark_q <= reg_wr.wdata[$bits(cnt_t)-1:0];
    end
  end

  // ------------------------------
  // Tick divider and event counter
  // ------------------------------
  assign tick_hit  = (tick_cnt_q >= tick_value_q);
  // One-shot parks at all-ones
  assign count_sat = oneshot_q && (count_q == '1);

  // Priority is clear, then load, then counting
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync || clear_pulse)
    begin
      tick_cnt_q <= '0;
      count_q    <= '0;
    end
    else if (load_pulse)
      count_q <= load_value_q;
    else if (enable_q)
    begin
      tick_cnt_q <= tick_hit ? '0 : tick_cnt_q + 1'b1;
      if (tick_hit && !count_sat)
        count_q <= count_q + 1'b1;
    end
  end

  // ------------------------------
  // Readback
  // ------------------------------
  always_comb
  begin
    cnt_rd.enable       = enable_q;
    cnt_rd.oneshot      = oneshot_q;
    cnt_rd.tick_value   = tick_value_q;
    cnt_rd.load_value   = load_value_q;
    cnt_rd.watermark    = watermark_q;
    cnt_rd.tick_cnt     = tick_cnt_q;
    cnt_rd.count        = count_q;
    cnt_rd.ge_watermark = (count_q >= watermark_q);
  end

  // Saturated one-shot count only leaves all-ones by command
  a_oneshot_sat: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (oneshot_q && (count_q == '1) && !clear_pulse && !load_pulse) |=> (count_q != '0));

endmodule

/* cl_vled.sv */
/*
 * Virtual LED block
 * Shadows the low hello half and masks it with synchronized DIP switches
 */
`timescale 1ns/10ps

module cl_vled
  import cl_hello_pkg::*;
#(
  parameter int DIP_SYNC_STAGES = 2
)
(
  input  logic clk_main_a0,
  input  logic rst_main_n_sync,
  input  led_t hello_low,
  input  led_t sh_cl_status_vdip,
  output led_t vled_q,
  output led_t cl_sh_status_vled
);

  // DIP synchronizer chain, last entry is the safe copy
  led_t dip_sync_q [DIP_SYNC_STAGES];

  // ------------------------------
  // DIP synchronizer
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      for (int i = 0; i < DIP_SYNC_STAGES; i++)
        dip_sync_q[i] <= '0;
    end
    else
    begin
      dip_sync_q[0] <= sh_cl_status_vdip;
      for (int i = 1; i < DIP_SYNC_STAGES; i++)
        dip_sync_q[i] <= dip_sync_q[i-1];
    end
  end

  // ------------------------------
  // LED shadow and output flop
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vled_q            <= '0;
      cl_sh_status_vled <= '0;
    end
    else
    begin
      vled_q            <= hello_low;
      // Switch off = LED dark
      cl_sh_status_vled <= vled_q & dip_sync_q[DIP_SYNC_STAGES-1];
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the hello-world peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_cl_hello_world \
  && ./obj_dir/Vtb_cl_hello_world > sim.log 2>&1 \
  || echo "Build or simulation did not complete"

cat sim.log 2>/dev/null
grep -qx "All tests passed" sim.log 2>/dev/null && echo "Result: PASS" && exit 0 \
  || { echo "Result: FAIL"; exit 1; }

/* sim.f */
cl_hello_pkg.sv
cl_ocl_ctrl.sv
cl_hello_reg.sv
cl_vled.sv
cl_tick_counter.sv
cl_hello_world.sv
tb_checker.sv
tb_cl_hello_world.sv

/* tb_checker.sv */
/*
 * Testbench checker for the hello-world peripheral
 * Keeps a register model, compares bus and LED results, reports per test
 */
`timescale 1ns/10ps

module tb_checker
  import cl_hello_pkg::*;
#(
  parameter int MAX_CYCLES = 2000
)
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  logic       awvalid,
  input  axil_addr_t awaddr,
  input  logic       awready,
  input  logic       wvalid,
  input  axil_data_t wdata,
  input  logic       wready,
  input  logic       bvalid,
  input  axil_resp_t bresp,
  input  logic       bready,
  input  logic       arvalid,
  input  axil_addr_t araddr,
  input  logic       arready,
  input  logic       rvalid,
  input  axil_data_t rdata,
  input  axil_resp_t rresp,
  input  logic       rready,
  input  led_t       sh_cl_status_vdip,
  input  led_t       cl_sh_status_vled,
  // Sequence control from the testbench top
  input  int         test_id,
  input  logic       test_end,
  input  logic       led_check,
  input  logic       all_done,
  output logic       timed_out,
  output logic       report_done,
  output int         error_total
);

  // Register model
  axil_data_t  hello_m;
  led_t        vled_m;
  logic        enable_m;
  logic        oneshot_m;
  tick_t       tick_value_m;
  cnt_t        load_value_m;
  cnt_t        wmark_m;
  tick_t       tick_cnt_m;
  cnt_t        count_m;
  // Bus tracking
  axil_addr_t  wr_addr_m;
  axil_addr_t  rd_addr_m;
  logic        rd_capture;
  logic        rd_expected;
  logic [33:0] exp_word;
  axil_data_t  exp_data;
  axil_resp_t  exp_resp;
  logic        hold_q;
  axil_data_t  held_data;
  axil_resp_t  held_resp;
  logic        busy_m;
  logic        wr_data_m;
  logic        b_due;
  logic        r_due;
  logic        clr;
  logic        ld;
  logic        rst_q;
  logic        summary_done;
  // Bookkeeping
  int cycle_cnt    = 0;
  int checks_test  = 0;
  int errors_test  = 0;
  int checks_all   = 0;
  int errors_all   = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  assign error_total = errors_all;

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset state";
      2:       return "hello readback";
      3:       return "LED masking";
      4:       return "counter config";
      5:       return "counter run";
      6:       return "error response";
      default: return "unknown";
    endcase
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  // Expected {rresp, rdata} for a read of the current model
  function automatic logic [33:0] ref_read(input axil_addr_t addr);
    axil_data_t d;
    axil_resp_t r;
    d = '0;
    r = RESP_OKAY;
    case (addr)
      HELLO_WORLD_ADDR:
      begin
        // Bytes come back in reverse order
        for (int i = 0; i < 4; i++)
          d[8*i +: 8] = hello_m[8*(3-i) +: 8];
      end
      VLED_ADDR:       d = {16'h0, vled_m};
      CNT_CTRL_ADDR:   d = {30'h0, oneshot_m, enable_m};
      CNT_TICK_ADDR:   d = {24'h0, tick_value_m};
      CNT_LOAD_ADDR:   d = {16'h0, load_value_m};
      CNT_WMARK_ADDR:  d = {16'h0, wmark_m};
      CNT_STATUS_ADDR: d = {7'h0, (count_m >= wmark_m), tick_cnt_m, count_m};
      default:         r = RESP_SLVERR;
    endcase
    return {r, d};
  endfunction

  // Counter rule for one edge giving {tick_cnt, count} from the pre-edge config
  function automatic logic [23:0] count_step(input logic clear_cmd, input logic load_cmd);
    tick_t tc;
    cnt_t  c;
    tc = tick_cnt_m;
    c  = count_m;
    if (clear_cmd)
    begin
      tc = '0;
      c  = '0;
    end
    else if (load_cmd)
      c = load_value_m;
    else if (enable_m)
    begin
      if (tick_cnt_m >= tick_value_m)
      begin
        tc = '0;
        // One-shot parks at all-ones
        if (!(oneshot_m && count_m == 16'hFFFF))
          c = count_m + 16'd1;
      end
      else
        tc = tick_cnt_m + 8'd1;
    end
    return {tc, c};
  endfunction

  task automatic compare_value(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
    checks_test++;
    checks_all++;
    if (got !== exp)
    begin
      errors_test++;
      errors_all++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", sig, got, exp, $time);
    end
  endtask

  // ------------------------------
  // Per-edge compare and model update
  // ------------------------------
  always @(posedge clk_main_a0)
  begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES && report_done !== 1'b1)
      timed_out <= 1'b1;
    if (!rst_main_n_sync)
    begin
      hello_m      = '0;
      vled_m       = '0;
      enable_m     = 1'b0;
      oneshot_m    = 1'b0;
      tick_value_m = '0;
      load_value_m = '0;
      wmark_m      = '0;
      tick_cnt_m   = '0;
      count_m      = '0;
      rd_capture   = 1'b0;
      rd_expected  = 1'b0;
      hold_q       = 1'b0;
      busy_m       = 1'b0;
      wr_data_m    = 1'b0;
      b_due        = 1'b0;
      r_due        = 1'b0;
      rst_q        = 1'b0;
      summary_done = 1'b0;
      timed_out   <= 1'b0;
      report_done <= 1'b0;
    end
    else
    begin
      // First edge out of reset
      if (!rst_q)
      begin
        compare_value("awready", {31'h0, awready}, 32'h1);
        compare_value("arready", {31'h0, arready}, 32'h1);
        compare_value("bvalid", {31'h0, bvalid}, 32'h0);
        compare_value("rvalid", {31'h0, rvalid}, 32'h0);
        compare_value("cl_sh_status_vled", {16'h0, cl_sh_status_vled}, 32'h0);
      end
      rst_q = 1'b1;

      // Channel readiness against the transaction in flight
      compare_value("wready", {31'h0, wready}, {31'h0, wr_data_m && wvalid});
      if (busy_m)
      begin
        compare_value("awready", {31'h0, awready}, 32'h0);
        compare_value("arready", {31'h0, arready}, 32'h0);
      end
      else
        compare_value("awready", {31'h0, awready}, 32'h1);

      // Responses one edge after the w handshake or the read capture
      if (b_due)
        compare_value("bvalid", {31'h0, bvalid}, 32'h1);
      if (r_due)
        compare_value("rvalid", {31'h0, rvalid}, 32'h1);
      b_due = wvalid && wready;
      r_due = rd_capture;
      if ((awvalid && awready) || (arvalid && arready))
        busy_m = 1'b1;
      if ((bvalid && bready) || (rvalid && rready))
        busy_m = 1'b0;
      if (awvalid && awready)
        wr_data_m = 1'b1;
      if (wvalid && wready)
        wr_data_m = 1'b0;

      // Read response must hold under back-pressure
      if (hold_q)
      begin
        compare_value("rvalid", {31'h0, rvalid}, 32'h1);
        compare_value("rdata", rdata, held_data);
        compare_value("rresp", {30'h0, rresp}, {30'h0, held_resp});
        compare_value("arready", {31'h0, arready}, 32'h0);
      end
      hold_q    = rvalid && !rready;
      held_data = rdata;
      held_resp = rresp;

      // DUT captures read data one edge after the ar handshake
      if (rd_capture)
      begin
        exp_word    = ref_read(rd_addr_m);
        exp_data    = exp_word[31:0];
        exp_resp    = exp_word[33:32];
        rd_capture  = 1'b0;
        rd_expected = 1'b1;
      end
      if (arvalid && arready)
      begin
        rd_addr_m  = araddr;
        rd_capture = 1'b1;
      end
      if (rvalid && rready)
      begin
        if (rd_expected)
        begin
          compare_value($sformatf("rdata at 0x%h", rd_addr_m), rdata, exp_data);
          compare_value($sformatf("rresp at 0x%h", rd_addr_m), {30'h0, rresp},
                        {30'h0, exp_resp});
          rd_expected = 1'b0;
        end
        else
        begin
          errors_test++;
          errors_all++;
          $display("A read response arrived with no read request pending at %0t", $time);
        end
      end
      if (bvalid && bready)
        compare_value("bresp", {30'h0, bresp}, {30'h0, RESP_OKAY});

      // Settled LED output
      if (led_check)
        compare_value("cl_sh_status_vled", {16'h0, cl_sh_status_vled},
                      {16'h0, hello_m[15:0] & sh_cl_status_vdip});

      // Model update where counter and shadow use the pre-edge values
      clr = 1'b0;
      ld  = 1'b0;
      if (wvalid && wready && wr_addr_m == CNT_CTRL_ADDR)
      begin
        clr = wdata[CTRL_CLEAR_BIT];
        ld  = wdata[CTRL_LOAD_BIT];
      end
      {tick_cnt_m, count_m} = count_step(clr, ld);
      vled_m = hello_m[15:0];
      if (wvalid && wready)
      begin
        case (wr_addr_m)
          HELLO_WORLD_ADDR: hello_m = wdata;
          CNT_CTRL_ADDR:
          begin
            enable_m  = wdata[CTRL_ENABLE_BIT];
            oneshot_m = wdata[CTRL_ONESHOT_BIT];
          end
          CNT_TICK_ADDR:    tick_value_m = wdata[7:0];
          CNT_LOAD_ADDR:    load_value_m = wdata[15:0];
          CNT_WMARK_ADDR:   wmark_m = wdata[15:0];
          default:          ;
        endcase
      end
      if (awvalid && awready)
        wr_addr_m = awaddr;

      // ------------------------------
      // Reporting
      // ------------------------------
      if (test_end)
      begin
        tests_run++;
        if (errors_test == 0)
          $display("Test %0d %s: PASS, %0d checks", test_id, test_name(test_id),
                   checks_test);
        else
        begin
          tests_failed++;
          $display("Test %0d %s: FAIL, %0d of %0d checks wrong", test_id,
                   test_name(test_id), errors_test, checks_test);
        end
        checks_test = 0;
        errors_test = 0;
      end
      if (all_done && !summary_done)
      begin
        $display("Summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks_all, errors_all);
        summary_done = 1'b1;
        report_done <= 1'b1;
      end
    end
  end

endmodule

/* tb_cl_hello_world.sv */
/*
 * Testbench top for the hello-world peripheral
 * Clock, reset, AXI-Lite stimulus and the test sequence
 */
`timescale 1ns/10ps

module tb_cl_hello_world
  import cl_hello_pkg::*;
();

  localparam int DIP_SYNC_STAGES = 2;
  localparam axil_addr_t UNMAPPED_ADDR = 32'h0000_0600;
  localparam axil_data_t CTRL_EN    = 32'h1 << CTRL_ENABLE_BIT;
  localparam axil_data_t CTRL_OS    = 32'h1 << CTRL_ONESHOT_BIT;
  localparam axil_data_t CTRL_LOAD  = 32'h1 << CTRL_LOAD_BIT;
  localparam axil_data_t CTRL_CLEAR = 32'h1 << CTRL_CLEAR_BIT;

  // Cycle limit from the length of the sequence
  localparam int N_WRITES    = 24;
  localparam int N_READS     = 26;
  localparam int N_TRANS     = N_WRITES + N_READS;
  localparam int MAX_HOLD    = 7;
  localparam int MAX_RUN     = 63;
  localparam int ONESHOT_RUN = 8;
  localparam int WAIT_CYCLES = 4 + N_READS * MAX_HOLD + MAX_RUN + ONESHOT_RUN
                             + 4 * (DIP_SYNC_STAGES + 3) + 8;
  localparam int MAX_CYCLES  = N_TRANS * 20 + WAIT_CYCLES + 200;

  logic       clk_main_a0 = 1'b0;
  logic       rst_main_n_sync;
  logic       awvalid;
  axil_addr_t awaddr;
  logic       awready;
  logic       wvalid;
  axil_data_t wdata;
  logic [3:0] wstrb;
  logic       wready;
  logic       bvalid;
  axil_resp_t bresp;
  logic       bready;
  logic       arvalid;
  axil_addr_t araddr;
  logic       arready;
  logic       rvalid;
  axil_data_t rdata;
  axil_resp_t rresp;
  logic       rready;
  led_t       sh_cl_status_vdip;
  led_t       cl_sh_status_vled;
  // Checker control and status
  int         test_id;
  logic       test_end;
  logic       led_check;
  logic       all_done;
  logic       timed_out;
  logic       report_done;
  int         error_total;
  logic [15:0] lfsr_q;

  cl_hello_world #(
    .DIP_SYNC_STAGES (DIP_SYNC_STAGES)
  ) i_cl_hello_world (.*);

  tb_checker #(
    .MAX_CYCLES (MAX_CYCLES)
  ) i_tb_checker (.*);

  // 20 ns period
  always #10 clk_main_a0 = ~clk_main_a0;

  // ------------------------------
  // Random source
  // ------------------------------
  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // ------------------------------
  // Bus tasks start and end 1 ns after a rising edge
  // ------------------------------
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    do
      @(posedge clk_main_a0);
    while (!awready);
    #1;
    awvalid = 1'b0;
    do
      @(posedge clk_main_a0);
    while (!wready);
    #1;
    wvalid = 1'b0;
    do
      @(posedge clk_main_a0);
    while (!bvalid);
    #1;
  endtask

  // Hold is the number of edges rvalid waits with rready low
  task automatic axil_read(input axil_addr_t addr, input int hold);
    arvalid = 1'b1;
    araddr  = addr;
    rready  = (hold == 0);
    do
      @(posedge clk_main_a0);
    while (!arready);
    #1;
    arvalid = 1'b0;
    do
      @(posedge clk_main_a0);
    while (!rvalid);
    if (hold != 0)
    begin
      repeat (hold - 1) @(posedge clk_main_a0);
      #1;
      rready = 1'b1;
      @(posedge clk_main_a0);
    end
    #1;
    rready = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk_main_a0);
      #1;
    end
  endtask

  task automatic check_led(input int settle);
    idle_cycles(settle);
    led_check = 1'b1;
    idle_cycles(1);
    led_check = 1'b0;
  endtask

  task automatic end_test();
    test_end = 1'b1;
    idle_cycles(1);
    test_end = 1'b0;
    test_id++;
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin : run_tests
    axil_data_t val;
    axil_data_t load_val;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = 4'hF;
    bready = 1'b1;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    sh_cl_status_vdip = '0;
    rst_main_n_sync = 1'b0;
    test_id = 1;
    test_end = 1'b0;
    led_check = 1'b0;
    all_done = 1'b0;
    lfsr_q = 16'd76;
    repeat (4) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;

    // Reset values
    axil_read(HELLO_WORLD_ADDR, 0);
    axil_read(VLED_ADDR, 0);
    check_led(DIP_SYNC_STAGES + 2);
    end_test();

    // Byte-reversed readback and LED shadow
    for (int i = 0; i < 4; i++)
    begin
      axil_write(HELLO_WORLD_ADDR, rand_bits(32));
      axil_read(HELLO_WORLD_ADDR, rand_bits(3));
      axil_read(VLED_ADDR, rand_bits(3));
    end
    end_test();

    // DIP masking of the LED output
    for (int i = 0; i < 3; i++)
    begin
      axil_write(HELLO_WORLD_ADDR, rand_bits(32));
      val = rand_bits(16);
      sh_cl_status_vdip = val[15:0];
      check_led(DIP_SYNC_STAGES + 2);
    end
    end_test();

    // Counter configuration with the counter stopped
    load_val = 32'h4000 | rand_bits(14);
    axil_write(CNT_LOAD_ADDR, load_val);
    axil_write(CNT_CTRL_ADDR, CTRL_LOAD);
    axil_read(CNT_STATUS_ADDR, rand_bits(3));
    axil_read(CNT_LOAD_ADDR, rand_bits(3));
    axil_read(CNT_CTRL_ADDR, rand_bits(3));
    axil_write(CNT_WMARK_ADDR, load_val + 32'd1);
    axil_read(CNT_WMARK_ADDR, rand_bits(3));
    axil_read(CNT_STATUS_ADDR, rand_bits(3));
    axil_write(CNT_WMARK_ADDR, load_val >> 1);
    axil_read(CNT_STATUS_ADDR, rand_bits(3));
    axil_write(CNT_CTRL_ADDR, CTRL_CLEAR);
    axil_read(CNT_STATUS_ADDR, rand_bits(3));
    axil_write(CNT_TICK_ADDR, rand_bits(8));
    axil_read(CNT_TICK_ADDR, rand_bits(3));
    axil_write(CNT_CTRL_ADDR, CTRL_OS);
    axil_read(CNT_CTRL_ADDR, rand_bits(3));
    end_test();

    // Free run for a random time
    axil_write(CNT_CTRL_ADDR, CTRL_CLEAR);
    axil_write(CNT_TICK_ADDR, rand_bits(3));
    axil_write(CNT_CTRL_ADDR, CTRL_EN);
    idle_cycles(rand_bits(6));
    axil_write(CNT_CTRL_ADDR, 32'h0);
    axil_read(CNT_STATUS_ADDR, rand_bits(3));
    // One-shot from just below all-ones
    axil_write(CNT_TICK_ADDR, 32'h0);
    axil_write(CNT_LOAD_ADDR, 32'h0000_FFFE);
    axil_write(CNT_CTRL_ADDR, CTRL_LOAD | CTRL_OS);
    axil_write(CNT_CTRL_ADDR, CTRL_EN | CTRL_OS);
    axil_read(CNT_CTRL_ADDR, rand_bits(3));
    idle_cycles(ONESHOT_RUN);
    axil_write(CNT_CTRL_ADDR, CTRL_OS);
    axil_read(CNT_STATUS_ADDR, rand_bits(3));
    end_test();

    // Unmapped access and a long back-pressure hold
    axil_read(UNMAPPED_ADDR, rand_bits(3));
    axil_write(UNMAPPED_ADDR, rand_bits(32));
    axil_read(HELLO_WORLD_ADDR, rand_bits(3));
    axil_read(CNT_STATUS_ADDR, rand_bits(3));
    axil_read(HELLO_WORLD_ADDR, MAX_HOLD);
    end_test();

    all_done = 1'b1;
  end

  // Verdict once the checker has reported or the cycle limit hit
  initial
  begin : verdict
    wait (report_done === 1'b1 || timed_out === 1'b1);
    if (timed_out === 1'b1)
      $display("Run stopped at the cycle limit of %0d before the sequence ended", MAX_CYCLES);
    if (timed_out !== 1'b1 && error_total == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
